//--- ifu_top.f
rtl/ifu_pkg.sv
rtl/fetch_pc.sv
rtl/icache_tag_array.sv
rtl/icache_data_sram.sv
rtl/icache.sv
rtl/ifu_top.sv
dv/ifu_asserts.sv
dv/ifu_tb.sv

//--- dv/ifu_tb.sv
`timescale 1ns/1ns

module ifu_tb;

	localparam ifu_pkg::addr_t RESET_PC = 64'h8000_0000;
	localparam int RAND_REDIRECTS = 240;
	localparam int MAX_CYCLES = 3000;  // About twice the cycles of all tests together

	logic                clk;
	logic                rst;
	logic                id_ready;
	logic                flush;
	ifu_pkg::addr_t      redirect_pc;
	ifu_pkg::addr_t      mem_addr;
	ifu_pkg::line_t      mem_line;
	ifu_pkg::fetch_rsp_t rsp;

	ifu_pkg::inst_t key;  // Pattern key of the memory model
	logic [31:0]    lfsr_q;
	string          test_name;
	int             error_count;
	int             test_errors_start;
	int             tests_run;
	int             tests_failed;
	int             cycle_count;

	ifu_top #(
		.RESET_PC (RESET_PC)
	) uut (
		.clk         (clk),
		.rst         (rst),
		.id_ready    (id_ready),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.mem_addr    (mem_addr),
		.mem_line    (mem_line),
		.rsp         (rsp)
	);

	always #2 clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory model and helpers
	function automatic ifu_pkg::inst_t mem_word(ifu_pkg::addr_t a, ifu_pkg::inst_t k);
		return {2'b00, a[31:2]} ^ k;  // Word address bits under the key
	endfunction

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			mem_line[32*i +: 32] = mem_word(mem_addr + 64'd4 * i, key);  // Word 0 at the bottom
		end
	end

	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];  // Taps 32, 22, 2, 1
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] rand_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	task automatic tick();
		@(posedge clk);
		#1;  // Drive and sample away from the edge
	endtask

	task automatic check_inst(ifu_pkg::inst_t exp, ifu_pkg::inst_t act);
		if (act !== exp) begin
			$display("MISMATCH %s inst expected %h actual %h", test_name, exp, act);
			error_count++;
		end
	endtask

	task automatic check_pc(ifu_pkg::addr_t exp, ifu_pkg::addr_t act, string field);
		if (act !== exp) begin
			$display("MISMATCH %s %s expected %h actual %h", test_name, field, exp, act);
			error_count++;
		end
	endtask

	task automatic check_valid(logic exp, logic act);
		if (act !== exp) begin
			$display("MISMATCH %s valid expected %b actual %b", test_name, exp, act);
			error_count++;
		end
	endtask

	task automatic open_test(string name);
		test_name = name;
		test_errors_start = error_count;
	endtask

	task automatic close_test();
		tests_run++;
		if (error_count > test_errors_start) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", test_name, error_count - test_errors_start);
		end else begin
			$display("test %s: passed", test_name);
		end
	endtask

	task automatic wait_valid(int limit);
		int n;
		n = 0;
		while (rsp.valid !== 1'b1 && n < limit) begin
			tick();
			n++;
		end
		if (rsp.valid !== 1'b1) begin
			$display("%s: no valid response within %0d cycles", test_name, limit);
			error_count++;
		end
	endtask

	// Flush in the current cycle, then expect one dead cycle and the target
	task automatic redirect(ifu_pkg::addr_t target);
		flush = 1'b1;
		redirect_pc = target;
		tick();
		flush = 1'b0;
		check_valid(1'b0, rsp.valid);
		tick();
		check_valid(1'b1, rsp.valid);
		check_pc(target, rsp.pc, "pc");
	endtask

	// Current cycle shows start; ends on the cycle showing the last word
	task automatic compare_run(ifu_pkg::addr_t start, int count, ifu_pkg::inst_t k);
		ifu_pkg::addr_t pc;
		pc = start;
		for (int i = 0; i < count; i++) begin
			if (i > 0) begin
				tick();
			end
			check_valid(1'b1, rsp.valid);
			check_pc(pc, rsp.pc, "pc");
			check_inst(mem_word(pc, k), rsp.inst);
			check_pc((pc + 64'd4) & ~64'hf, mem_addr, "mem_addr");  // Line of the next request
			pc = pc + 64'd4;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tests
	task automatic sequential_fetch();
		open_test("sequential_fetch");
		key = '0;
		wait_valid(8);
		compare_run(RESET_PC, 24, key);
		close_test();
	endtask

	task automatic cached_hits();
		ifu_pkg::addr_t base;
		base = 64'h8000_2000;
		open_test("cached_hits");
		key = '0;
		redirect(base);
		compare_run(base, 16, key);  // Four lines filled under key 0
		key = 32'h5a5a_0f0f;
		redirect(base);
		compare_run(base, 16, 32'h0);  // Cached copies keep the old key
		tick();
		compare_run(base + 64'd64, 8, key);  // Fresh lines see the new key
		close_test();
	endtask

	task automatic stall_hold();
		ifu_pkg::fetch_rsp_t held;
		open_test("stall_hold");
		key = 32'h3c3c_0001;
		redirect(64'h8000_3000);
		compare_run(64'h8000_3000, 3, key);
		held = rsp;
		id_ready = 1'b0;
		for (int i = 0; i < 6; i++) begin
			tick();
			check_inst(held.inst, rsp.inst);
			check_pc(held.pc, rsp.pc, "pc");
			check_valid(held.valid, rsp.valid);
		end
		id_ready = 1'b1;  // Release cycle still shows the held word
		tick();
		compare_run(held.pc + 64'd4, 6, key);
		close_test();
	endtask

	task automatic flush_redirect();
		open_test("flush_redirect");
		redirect(64'h8000_4abc);
		compare_run(64'h8000_4abc, 6, key);  // Miss, then across a line boundary
		redirect(64'h8000_3004);
		compare_run(64'h8000_3004, 4, key);  // Lines left cached by stall_hold
		close_test();
	endtask

	task automatic set_capacity();
		ifu_pkg::addr_t line_addr [5];
		ifu_pkg::inst_t old_key;
		ifu_pkg::inst_t new_key;
		int             old_hits;
		int             new_hits;
		open_test("set_capacity");
		old_key = 32'h0000_c0de;
		new_key = 32'h0000_beef;
		old_hits = 0;
		new_hits = 0;
		for (int k = 0; k < 5; k++) begin
			line_addr[k] = 64'h8001_0200 + 64'h400 * k;  // Set 0x20, tag differs
		end
		key = old_key;
		for (int k = 0; k < 5; k++) begin
			redirect(line_addr[k]);
			compare_run(line_addr[k], 4, key);
		end
		key = new_key;
		for (int k = 0; k < 5; k++) begin
			redirect(line_addr[k]);
			if (rsp.inst === mem_word(line_addr[k], old_key)) begin
				old_hits++;
			end else if (rsp.inst === mem_word(line_addr[k], new_key)) begin
				new_hits++;
			end else begin
				check_inst(mem_word(line_addr[k], new_key), rsp.inst);
			end
		end
		if (old_hits > 4) begin
			$display("%s: %0d lines of one set stayed cached in four ways", test_name, old_hits);
			error_count++;
		end
		if (new_hits < 1) begin
			$display("%s: no line of the overfilled set came back from memory", test_name);
			error_count++;
		end
		close_test();
	endtask

	task automatic random_redirects();
		ifu_pkg::addr_t target;
		int             run_len;
		open_test("random_redirects");
		key = 32'h0f1e_2d3c;
		for (int n = 0; n < RAND_REDIRECTS; n++) begin
			target = 64'h9000_0000 + (64'(rand_bits(16)) << 2);  // Untouched region
			run_len = int'(rand_bits(3)) + 1;
			redirect(target);
			compare_run(target, run_len, key);
		end
		close_test();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Run control
	initial begin
		cycle_count = 0;
		while (cycle_count < MAX_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run exceeded %0d clock cycles", MAX_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

	initial begin
		int assert_fails;
		clk = 1'b0;
		rst = 1'b1;
		id_ready = 1'b1;
		flush = 1'b0;
		redirect_pc = '0;
		key = '0;
		lfsr_q = 32'ha53b6601;
		error_count = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (16) begin
			tick();
		end
		rst = 1'b0;
		sequential_fetch();
		cached_hits();
		stall_hold();
		flush_redirect();
		set_capacity();
		random_redirects();
		assert_fails = uut.u_icache.u_asserts.fail_count;
		$display("tests run %0d, tests failed %0d, check errors %0d, assertion failures %0d",
			tests_run, tests_failed, error_count, assert_fails);
		if (error_count == 0 && assert_fails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- dv/ifu_asserts.sv
`timescale 1ns/1ns

module ifu_asserts (
	input logic                 clk,
	input logic                 rst,
	input logic                 id_ready,
	input logic                 flush,
	input ifu_pkg::way_mask_t   hit_way,
	input ifu_pkg::fetch_rsp_t  rsp
);

	int fail_count = 0;  // Tally for the end of run summary

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup and output rules
	hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_way))
		else begin
			$error("hit_way has more than one way set: %b", hit_way);
			fail_count++;
		end

	stall_stable: assert property (@(posedge clk) disable iff (rst)
		!id_ready |=> $stable(rsp))
		else begin
			$error("rsp changed while decode was stalled");
			fail_count++;
		end

	kill_valid: assert property (@(posedge clk)
		(rst || (flush && id_ready)) |=> !rsp.valid)
		else begin
			$error("rsp.valid high in the cycle after a flush or reset");
			fail_count++;
		end

endmodule

bind icache ifu_asserts u_asserts (
	.clk      (clk),
	.rst      (rst),
	.id_ready (id_ready),
	.flush    (flush),
	.hit_way  (hit_way),
	.rsp      (rsp)
);

//--- rtl/ifu_top.sv
`timescale 1ns/1ns

module ifu_top #(
	parameter ifu_pkg::addr_t RESET_PC = 64'h8000_0000
) (
	input  logic                clk,
	input  logic                rst,
	input  logic                id_ready,
	input  logic                flush,
	input  ifu_pkg::addr_t      redirect_pc,
	output ifu_pkg::addr_t      mem_addr,
	input  ifu_pkg::line_t      mem_line,
	output ifu_pkg::fetch_rsp_t rsp
);

	ifu_pkg::addr_t req_pc;
	ifu_pkg::addr_t req_pc_prev;
	logic           req_valid;

	fetch_pc #(
		.RESET_PC (RESET_PC)
	) u_fetch_pc (
		.clk         (clk),
		.rst         (rst),
		.id_ready    (id_ready),
		.flush       (flush),
		.redirect_pc (redirect_pc),
		.req_pc      (req_pc),
		.req_pc_prev (req_pc_prev),
		.req_valid   (req_valid)
	);

	icache #(
		.SRAM_DEPTH (ifu_pkg::NUM_SETS)  // One line per set in each way
	) u_icache (
		.clk         (clk),
		.rst         (rst),
		.req_pc      (req_pc),
		.req_pc_prev (req_pc_prev),
		.req_valid   (req_valid),
		.id_ready    (id_ready),
		.flush       (flush),
		.mem_addr    (mem_addr),
		.mem_line    (mem_line),
		.rsp         (rsp)
	);

endmodule

//--- rtl/icache.sv
`timescale 1ns/1ns

module icache #(
	parameter int SRAM_DEPTH = 64
) (
	input  logic                clk,
	input  logic                rst,
	input  ifu_pkg::addr_t      req_pc,
	input  ifu_pkg::addr_t      req_pc_prev,
	input  logic                req_valid,
	input  logic                id_ready,
	input  logic                flush,
	output ifu_pkg::addr_t      mem_addr,
	input  ifu_pkg::line_t      mem_line,
	output ifu_pkg::fetch_rsp_t rsp
);

	ifu_pkg::index_t     lookup_index;
	ifu_pkg::tag_t       lookup_tag;
	ifu_pkg::way_mask_t  hit_way;
	ifu_pkg::way_mask_t  hit_q;      // Hit vector of the access in flight
	ifu_pkg::way_mask_t  repl_ptr;   // Rotating victim pointer
	ifu_pkg::way_mask_t  way_en;
	logic                access;
	logic                fill_en;
	logic                rsp_valid_q;
	ifu_pkg::line_t      line_q;     // Refilled line for forwarding
	ifu_pkg::line_t      way_rdata [ifu_pkg::NUM_WAYS];
	ifu_pkg::line_t      line_sel;
	ifu_pkg::inst_t [3:0] line_words;
	ifu_pkg::inst_t      inst_sel;
	ifu_pkg::hold_state_e hold_q;
	ifu_pkg::inst_t      hold_inst;

	assign lookup_index = ifu_pkg::addr_index(req_pc);
	assign lookup_tag   = ifu_pkg::addr_tag(req_pc);

	assign access  = req_valid & id_ready & ~flush;
	assign fill_en = access & (hit_way == '0);  // Miss refills in the same cycle
	assign mem_addr = {req_pc[63:ifu_pkg::INDEX_LSB], {ifu_pkg::INDEX_LSB{1'b0}}};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Tag and data arrays
	icache_tag_array u_tags (
		.clk          (clk),
		.rst          (rst),
		.lookup_index (lookup_index),
		.lookup_tag   (lookup_tag),
		.hit_way      (hit_way),
		.fill_en      (fill_en),
		.fill_way     (repl_ptr)
	);

	for (genvar w = 0; w < ifu_pkg::NUM_WAYS; w++) begin : g_way
		assign way_en[w] = access & (hit_way[w] | (fill_en & repl_ptr[w]));

		icache_data_sram #(
			.DEPTH (SRAM_DEPTH)
		) u_sram (
			.clk   (clk),
			.en    (way_en[w]),
			.we    (fill_en & repl_ptr[w]),
			.index (lookup_index),
			.wdata (mem_line),
			.rdata (way_rdata[w])
		);
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pipeline control
	always_ff @(posedge clk) begin
		if (rst) begin
			hit_q       <= '0;
			repl_ptr    <= 4'b0001;
			rsp_valid_q <= 1'b0;
		end else if (id_ready) begin
			if (flush) begin
				hit_q       <= '0;
				rsp_valid_q <= 1'b0;  // Kill the access in flight
			end else begin
				hit_q       <= hit_way;
				repl_ptr    <= {repl_ptr[2:0], repl_ptr[3]};
				rsp_valid_q <= req_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			line_q <= mem_line;
		end
	end

	// Way mux, forwarded line when the access missed
	always_comb begin
		case (hit_q)
			4'b0001: line_sel = way_rdata[0];
			4'b0010: line_sel = way_rdata[1];
			4'b0100: line_sel = way_rdata[2];
			4'b1000: line_sel = way_rdata[3];
			default: line_sel = line_q;
		endcase
	end

	assign line_words = line_sel;
	assign inst_sel   = line_words[req_pc_prev[3:2]];  // Word select by offset

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stall hold
	always_ff @(posedge clk) begin
		if (rst) begin
			hold_q <= ifu_pkg::HOLD_IDLE;
		end else begin
			case (hold_q)
				ifu_pkg::HOLD_IDLE: if (!id_ready) hold_q <= ifu_pkg::HOLD_KEEP;
				ifu_pkg::HOLD_KEEP: if (id_ready) hold_q <= ifu_pkg::HOLD_IDLE;
				default: hold_q <= ifu_pkg::HOLD_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (hold_q == ifu_pkg::HOLD_IDLE && !id_ready) begin
			hold_inst <= inst_sel;  // Capture on the first stalled cycle
		end
	end

	assign rsp.inst  = (hold_q == ifu_pkg::HOLD_KEEP) ? hold_inst : inst_sel;
	assign rsp.pc    = req_pc_prev;
	assign rsp.valid = rsp_valid_q;

endmodule

//--- rtl/icache_data_sram.sv
`timescale 1ns/1ns

module icache_data_sram #(
	parameter int DEPTH = 64
) (
	input  logic            clk,
	input  logic            en,
	input  logic            we,
	input  ifu_pkg::index_t index,
	input  ifu_pkg::line_t  wdata,
	output ifu_pkg::line_t  rdata
);

	ifu_pkg::line_t mem [DEPTH];

	// Single port, read-first; rdata holds while en is low
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[index];  // Old contents on a write
			if (we) begin
				mem[index] <= wdata;
			end
		end
	end

endmodule

//--- rtl/icache_tag_array.sv
`timescale 1ns/1ns

module icache_tag_array (
	input  logic               clk,
	input  logic               rst,
	input  ifu_pkg::index_t    lookup_index,
	input  ifu_pkg::tag_t      lookup_tag,
	output ifu_pkg::way_mask_t hit_way,
	input  logic               fill_en,
	input  ifu_pkg::way_mask_t fill_way
);

	// One tag bank and one valid vector per way
	ifu_pkg::tag_t tag_mem [ifu_pkg::NUM_WAYS][ifu_pkg::NUM_SETS];
	logic [ifu_pkg::NUM_SETS-1:0] valid_q [ifu_pkg::NUM_WAYS];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Lookup
	always_comb begin
		for (int w = 0; w < ifu_pkg::NUM_WAYS; w++) begin
			hit_way[w] = valid_q[w][lookup_index] &&
				(tag_mem[w][lookup_index] == lookup_tag);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Refill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < ifu_pkg::NUM_WAYS; w++) begin
				valid_q[w] <= '0;
			end
		end else if (fill_en) begin
			for (int w = 0; w < ifu_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					valid_q[w][lookup_index] <= 1'b1;  // Victim way now owns the line
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < ifu_pkg::NUM_WAYS; w++) begin
				if (fill_way[w]) begin
					tag_mem[w][lookup_index] <= lookup_tag;
				end
			end
		end
	end

endmodule

//--- rtl/fetch_pc.sv
`timescale 1ns/1ns

module fetch_pc #(
	parameter ifu_pkg::addr_t RESET_PC = 64'h8000_0000
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           id_ready,
	input  logic           flush,
	input  ifu_pkg::addr_t redirect_pc,
	output ifu_pkg::addr_t req_pc,
	output ifu_pkg::addr_t req_pc_prev,
	output logic           req_valid
);

	ifu_pkg::addr_t pc_q;
	ifu_pkg::addr_t pc_prev_q;
	logic           valid_q;
	logic           accept;

	assign accept = valid_q & id_ready;  // Cache takes the current PC this cycle

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PC register
	always_ff @(posedge clk) begin
		if (rst) begin
			pc_q      <= RESET_PC;
			pc_prev_q <= RESET_PC;
			valid_q   <= 1'b0;
		end else begin
			valid_q <= 1'b1;  // First request one cycle after reset
			if (id_ready) begin
				if (flush) begin
					pc_q <= redirect_pc;  // Restart at the target
				end else if (valid_q) begin
					pc_q <= pc_q + 64'd4;
				end
			end
			if (accept) begin
				pc_prev_q <= pc_q;  // Address of the access now in flight
			end
		end
	end

	assign req_pc      = pc_q;
	assign req_pc_prev = pc_prev_q;
	assign req_valid   = valid_q;

endmodule

//--- rtl/ifu_pkg.sv
package ifu_pkg;

	localparam int NUM_WAYS = 4;
	localparam int NUM_SETS = 64;

	localparam int INDEX_LSB = 4;  // Bits 3:0 are the byte offset in a line
	localparam int TAG_LSB = 10;   // Bits 9:4 are the set index

	typedef logic [63:0] addr_t;
	typedef logic [31:0] inst_t;
	typedef logic [127:0] line_t;  // Four instructions
	typedef logic [5:0] index_t;
	typedef logic [53:0] tag_t;
	typedef logic [NUM_WAYS-1:0] way_mask_t;  // One-hot or all zero

	// Result toward decode
	typedef struct packed {
		inst_t inst;
		addr_t pc;
		logic  valid;
	} fetch_rsp_t;

	typedef enum logic {
		HOLD_IDLE,  // Output follows the cache read
		HOLD_KEEP   // Output replays the captured instruction
	} hold_state_e;

	function automatic index_t addr_index(addr_t a);
		return a[TAG_LSB-1:INDEX_LSB];
	endfunction

	function automatic tag_t addr_tag(addr_t a);
		return a[63:TAG_LSB];
	endfunction

endpackage
